// File: design/ex_isa_pkg.sv
package ex_isa_pkg;

  //////////////////////////////////////////////////////////////////////
  // Datapath widths
  //////////////////////////////////////////////////////////////////////

  // Integer register width
  localparam int unsigned XLEN = 32;

  // Register file address, upper half reserved for extension registers
  localparam int unsigned REG_ADDR_W = 6;

  // Shift amount width, enough to cover a full word
  localparam int unsigned SHAMT_W = $clog2(XLEN);

  // Operation field widths
  localparam int unsigned ALU_OP_W = 4;
  localparam int unsigned MUL_OP_W = 2;

  //////////////////////////////////////////////////////////////////////
  // Operation encodings
  //////////////////////////////////////////////////////////////////////

  // ALU operations, the whole 4-bit space is used
  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    // Set-less-than writes the flag into bit 0
    ALU_SLTS = 4'h8,
    ALU_SLTU = 4'h9,
    // Branch compares only drive the decision flag
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LTS  = 4'hc,
    ALU_LTU  = 4'hd,
    ALU_GES  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

  // Multiplier operations, code 3 is unused
  typedef enum logic [MUL_OP_W-1:0] {
    MUL_MUL = 2'd0,
    MUL_MAC = 2'd1,
    MUL_H   = 2'd2
  } mul_op_e;

endpackage

// File: design/ex_pipe_pkg.sv
package ex_pipe_pkg;

  import ex_isa_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Requests from decode into the execute units
  //////////////////////////////////////////////////////////////////////

  // One ALU request, 100 bits
  typedef struct packed {
    // Operation to perform
    alu_op_e         operator;
    // Source operands
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    // Jump target, passed straight to fetch
    logic [XLEN-1:0] operand_c;
  } alu_req_t;

  // One multiplier request, 100 bits
  typedef struct packed {
    // MUL, MAC or MULH
    mul_op_e         operator;
    // Bit 0 marks op_a signed, bit 1 marks op_b signed
    logic [1:0]      signed_mode;
    // Factors
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    // Accumulator for MAC
    logic [XLEN-1:0] op_c;
  } mult_req_t;

  //////////////////////////////////////////////////////////////////////
  // Register file write, used by both write ports
  //////////////////////////////////////////////////////////////////////

  // One write, 39 bits
  typedef struct packed {
    // Write strobe
    logic                  we;
    // Destination register
    logic [REG_ADDR_W-1:0] waddr;
    // Write data
    logic [XLEN-1:0]       wdata;
  } rf_wr_t;

endpackage

// File: design/ex_alu.sv
`timescale 1ns/1ns

module ex_alu (
  input  ex_pipe_pkg::alu_req_t        alu_req_i,
  output logic [ex_isa_pkg::XLEN-1:0]  result_o,
  output logic                         cmp_result_o
);

  import ex_isa_pkg::*;

  // Adder path
  logic               sub_en;
  logic               signed_cmp;
  logic [XLEN:0]      adder_a;
  logic [XLEN:0]      adder_b;
  logic [XLEN:0]      adder_sum;
  logic               is_equal;
  logic               is_less;

  // Shifter path
  logic               shift_left;
  logic               shift_arith;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    shift_in;
  logic signed [XLEN:0] shift_ext;
  logic [XLEN:0]      shift_full;
  logic [XLEN-1:0]    shift_result;

  //////////////////////////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////////////////////////

  // Everything except ADD subtracts, compares included
  assign sub_en     = (alu_req_i.operator != ALU_ADD);
  assign signed_cmp = alu_req_i.operator inside {ALU_SLTS, ALU_LTS, ALU_GES};

  // One extra bit so the carry out is the sign of a - b
  assign adder_a = {signed_cmp & alu_req_i.operand_a[XLEN-1], alu_req_i.operand_a};
  assign adder_b = {signed_cmp & alu_req_i.operand_b[XLEN-1], alu_req_i.operand_b}
                   ^ {(XLEN+1){sub_en}};

  // Two's complement, the +1 comes in as carry
  assign adder_sum = adder_a + adder_b + {{XLEN{1'b0}}, sub_en};

  // Equal when the low word of a - b is zero
  assign is_equal = (adder_sum[XLEN-1:0] == '0);
  assign is_less  = adder_sum[XLEN];

  //////////////////////////////////////////////////////////////////////
  // Shared shifter
  //////////////////////////////////////////////////////////////////////

  assign shift_left  = (alu_req_i.operator == ALU_SLL);
  assign shift_arith = (alu_req_i.operator == ALU_SRA);
  assign shamt       = alu_req_i.operand_b[SHAMT_W-1:0];

  // Left shift done as right shift on the bit-reversed word
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      shift_in[i] = shift_left ? alu_req_i.operand_a[XLEN-1-i] : alu_req_i.operand_a[i];
    end
  end

  // Sign bit only fills in for SRA
  assign shift_ext  = {shift_arith & shift_in[XLEN-1], shift_in};
  assign shift_full = shift_ext >>> shamt;

  // Undo the reversal for SLL
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      shift_result[i] = shift_left ? shift_full[XLEN-1-i] : shift_full[i];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result and compare flag
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    result_o     = '0;
    cmp_result_o = 1'b0;
    unique case (alu_req_i.operator)
      ALU_ADD, ALU_SUB:          result_o = adder_sum[XLEN-1:0];
      ALU_AND:                   result_o = alu_req_i.operand_a & alu_req_i.operand_b;
      ALU_OR:                    result_o = alu_req_i.operand_a | alu_req_i.operand_b;
      ALU_XOR:                   result_o = alu_req_i.operand_a ^ alu_req_i.operand_b;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      // Set-less-than also drives bit 0
      ALU_SLTS, ALU_SLTU: begin
        cmp_result_o = is_less;
        result_o     = {{(XLEN-1){1'b0}}, is_less};
      end
      // Branch conditions
      ALU_EQ:             cmp_result_o = is_equal;
      ALU_NE:             cmp_result_o = ~is_equal;
      ALU_LTS, ALU_LTU:   cmp_result_o = is_less;
      ALU_GES, ALU_GEU:   cmp_result_o = ~is_less;
    endcase
  end

endmodule

// File: design/ex_mult.sv
`timescale 1ns/1ns

module ex_mult (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         enable_i,
  input  ex_pipe_pkg::mult_req_t       mult_req_i,
  input  logic                         ex_ready_i,
  output logic [ex_isa_pkg::XLEN-1:0]  result_o,
  output logic                         ready_o,
  output logic                         multicycle_o
);

  import ex_isa_pkg::*;

  // MULH sequencing
  typedef enum logic {
    MULH_IDLE,
    MULH_FINISH
  } mulh_state_e;

  mulh_state_e              state_q;
  mulh_state_e              state_d;
  logic                     mulh_start;

  // Product path
  logic signed [XLEN:0]     op_a_ext;
  logic signed [XLEN:0]     op_b_ext;
  logic signed [2*XLEN+1:0] product;
  logic [XLEN-1:0]          prod_lo;
  logic [XLEN-1:0]          prod_hi;
  logic [XLEN-1:0]          mulh_q;

  //////////////////////////////////////////////////////////////////////
  // 33x33 signed multiply covers every signedness mix
  //////////////////////////////////////////////////////////////////////

  // Extend each factor as signed_mode asks
  assign op_a_ext = {mult_req_i.signed_mode[0] & mult_req_i.op_a[XLEN-1], mult_req_i.op_a};
  assign op_b_ext = {mult_req_i.signed_mode[1] & mult_req_i.op_b[XLEN-1], mult_req_i.op_b};

  assign product = op_a_ext * op_b_ext;
  assign prod_lo = product[XLEN-1:0];
  assign prod_hi = product[2*XLEN-1:XLEN];

  //////////////////////////////////////////////////////////////////////
  // MULH state machine
  //////////////////////////////////////////////////////////////////////

  // A new MULH only starts from IDLE
  assign mulh_start = enable_i && (mult_req_i.operator == MUL_H) && (state_q == MULH_IDLE);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MULH_IDLE:   if (mulh_start) state_d = MULH_FINISH;
      // Leave only once EX hands the result on
      MULH_FINISH: if (ex_ready_i) state_d = MULH_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // High word kept for the FINISH cycle and any stall after it
  always_ff @(posedge clk) begin
    if (mulh_start) begin
      mulh_q <= prod_hi;
    end
  end

  // Stall only in the first MULH cycle
  assign ready_o      = ~mulh_start;
  assign multicycle_o = (state_q == MULH_FINISH);

  // Result select
  always_comb begin
    if (state_q == MULH_FINISH) begin
      result_o = mulh_q;
    end else begin
      unique case (mult_req_i.operator)
        MUL_MAC: result_o = prod_lo + mult_req_i.op_c;
        MUL_H:   result_o = prod_hi;
        default: result_o = prod_lo;
      endcase
    end
  end

  // MULH never stalls EX for more than one cycle
  mult_stall_single_a : assert property (
    @(posedge clk) disable iff (!rst_n) !ready_o |=> ready_o
  );

endmodule

// File: design/ex_writeback.sv
`timescale 1ns/1ns

module ex_writeback (
  input  logic                               clk,
  input  logic                               rst_n,
  // Result sources
  input  logic [ex_isa_pkg::XLEN-1:0]        alu_result_i,
  input  logic [ex_isa_pkg::XLEN-1:0]        mult_result_i,
  input  logic [ex_isa_pkg::XLEN-1:0]        csr_rdata_i,
  input  logic [ex_isa_pkg::XLEN-1:0]        lsu_rdata_i,
  // Control from decode and stall logic
  input  logic                               mult_en_i,
  input  logic                               csr_access_i,
  input  logic                               regfile_alu_we_i,
  input  logic                               regfile_we_i,
  input  logic                               lsu_err_i,
  input  logic                               ex_valid_i,
  input  logic                               wb_ready_i,
  // Destinations
  input  logic [ex_isa_pkg::REG_ADDR_W-1:0]  regfile_alu_waddr_i,
  input  logic [ex_isa_pkg::REG_ADDR_W-1:0]  regfile_waddr_i,
  // Write ports
  output ex_pipe_pkg::rf_wr_t                regfile_alu_fw_o,
  output ex_pipe_pkg::rf_wr_t                regfile_wb_o
);

  import ex_isa_pkg::*;

  // Load write that survives an LSU error
  logic                  lsu_we_d;
  logic                  lsu_we_q;
  logic [REG_ADDR_W-1:0] lsu_waddr_q;

  //////////////////////////////////////////////////////////////////////
  // ALU write port, forwarded in the same cycle
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    regfile_alu_fw_o.we    = regfile_alu_we_i;
    regfile_alu_fw_o.waddr = regfile_alu_waddr_i;
    // CSR wins over the multiplier, ALU is the fallback
    if (csr_access_i) begin
      regfile_alu_fw_o.wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_fw_o.wdata = mult_result_i;
    end else begin
      regfile_alu_fw_o.wdata = alu_result_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // EX/WB register for the LSU write port
  //////////////////////////////////////////////////////////////////////

  // Faulting loads never reach the register file
  assign lsu_we_d = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else if (ex_valid_i) begin
      lsu_we_q <= lsu_we_d;
    end else if (wb_ready_i) begin
      // Nothing new from EX, drain the slot
      lsu_we_q <= 1'b0;
    end
  end

  // Address follows only real writes
  always_ff @(posedge clk) begin
    if (ex_valid_i && lsu_we_d) begin
      lsu_waddr_q <= regfile_waddr_i;
    end
  end

  // Load data arrives from the LSU in the WB cycle
  always_comb begin
    regfile_wb_o.we    = lsu_we_q;
    regfile_wb_o.waddr = lsu_waddr_q;
    regfile_wb_o.wdata = lsu_rdata_i;
  end

  // EX never signals valid into a stalled WB
  ex_valid_wb_ready_a : assert property (
    @(posedge clk) disable iff (!rst_n) ex_valid_i |-> wb_ready_i
  );

endmodule

// File: design/ex_stage.sv
`timescale 1ns/1ns

module ex_stage (
  input  logic                               clk,
  input  logic                               rst_n,
  // ALU
  input  logic                               alu_en_i,
  input  ex_pipe_pkg::alu_req_t              alu_req_i,
  // Multiplier
  input  logic                               mult_en_i,
  input  ex_pipe_pkg::mult_req_t             mult_req_i,
  output logic                               mult_multicycle_o,
  // CSR read
  input  logic                               csr_access_i,
  input  logic [ex_isa_pkg::XLEN-1:0]        csr_rdata_i,
  // LSU
  input  logic                               lsu_en_i,
  input  logic [ex_isa_pkg::XLEN-1:0]        lsu_rdata_i,
  input  logic                               lsu_ready_ex_i,
  input  logic                               lsu_err_i,
  input  logic                               branch_in_ex_i,
  // Destinations from decode
  input  logic                               regfile_alu_we_i,
  input  logic [ex_isa_pkg::REG_ADDR_W-1:0]  regfile_alu_waddr_i,
  input  logic                               regfile_we_i,
  input  logic [ex_isa_pkg::REG_ADDR_W-1:0]  regfile_waddr_i,
  input  logic                               wb_ready_i,
  // Write ports
  output ex_pipe_pkg::rf_wr_t                regfile_alu_fw_o,
  output ex_pipe_pkg::rf_wr_t                regfile_wb_o,
  // To fetch
  output logic [ex_isa_pkg::XLEN-1:0]        jump_target_o,
  output logic                               branch_decision_o,
  // Stall control
  output logic                               ex_ready_o,
  output logic                               ex_valid_o
);

  import ex_isa_pkg::*;

  logic [XLEN-1:0] alu_result;
  logic            alu_cmp_result;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;
  // Common condition for ready and valid
  logic            units_ready;

  //////////////////////////////////////////////////////////////////////
  // Execute units
  //////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_writeback u_writeback (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_we_i        (regfile_we_i),
    .lsu_err_i           (lsu_err_i),
    .ex_valid_i          (ex_valid_o),
    .wb_ready_i          (wb_ready_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .regfile_alu_fw_o    (regfile_alu_fw_o),
    .regfile_wb_o        (regfile_wb_o)
  );

  // Branches resolve here
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_req_i.operand_c;

  // Stall logic, a branch completes without waiting on WB
  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // Decode issues to one result source at a time
  one_result_source_a : assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0({alu_en_i, mult_en_i, csr_access_i})
  );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Half of the 8 ns period
  localparam int unsigned HALF_PERIOD  = 4;
  localparam int unsigned RESET_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

  // Release on a falling edge so every rising edge sees a stable level
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) begin
      @(posedge clk_o);
    end
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: verification/ex_stage_tb.sv
`timescale 1ns/1ns

module ex_stage_tb;

  import ex_isa_pkg::*;
  import ex_pipe_pkg::*;

  localparam int unsigned NUM_INSTR  = 400;
  localparam int unsigned MAX_WAIT   = 50;
  localparam int unsigned MAX_RESET  = 20;

  logic clk, rst_n;
  integer seed;
  // DUT inputs
  logic alu_en, mult_en, csr_access, lsu_en, lsu_ready_ex, lsu_err;
  logic branch_in_ex, regfile_alu_we, regfile_we, wb_ready;
  alu_req_t alu_req;
  mult_req_t mult_req;
  logic [XLEN-1:0] csr_rdata, lsu_rdata;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr, regfile_waddr;
  // DUT outputs
  rf_wr_t regfile_alu_fw, regfile_wb;
  logic [XLEN-1:0] jump_target;
  logic branch_decision, mult_multicycle, ex_ready, ex_valid;
  // Reference state
  logic mulh_busy_q, wb_we_q;
  logic [REG_ADDR_W-1:0] wb_waddr_q;
  logic mulh_start_exp, units_ready_exp, ex_ready_exp, ex_valid_exp, check_fw;
  rf_wr_t fw_exp;
  // How often the rarer cases were reached
  int unsigned mulh_count, bypass_count, hold_count;

  tb_clock_gen u_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  ex_stage DUT (
    .clk(clk), .rst_n(rst_n),
    .alu_en_i(alu_en), .alu_req_i(alu_req),
    .mult_en_i(mult_en), .mult_req_i(mult_req), .mult_multicycle_o(mult_multicycle),
    .csr_access_i(csr_access), .csr_rdata_i(csr_rdata),
    .lsu_en_i(lsu_en), .lsu_rdata_i(lsu_rdata), .lsu_ready_ex_i(lsu_ready_ex),
    .lsu_err_i(lsu_err), .branch_in_ex_i(branch_in_ex),
    .regfile_alu_we_i(regfile_alu_we), .regfile_alu_waddr_i(regfile_alu_waddr),
    .regfile_we_i(regfile_we), .regfile_waddr_i(regfile_waddr), .wb_ready_i(wb_ready),
    .regfile_alu_fw_o(regfile_alu_fw), .regfile_wb_o(regfile_wb),
    .jump_target_o(jump_target), .branch_decision_o(branch_decision),
    .ex_ready_o(ex_ready), .ex_valid_o(ex_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference models
  //////////////////////////////////////////////////////////////////////

  function automatic logic [XLEN-1:0] expected_alu_result(alu_req_t req);
    logic [XLEN-1:0]    a;
    logic [XLEN-1:0]    b;
    logic [SHAMT_W-1:0] sh;
    a  = req.operand_a;
    b  = req.operand_b;
    sh = b[SHAMT_W-1:0];
    case (req.operator)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return $signed(a) >>> sh;
      ALU_SLTS: return XLEN'($signed(a) < $signed(b));
      ALU_SLTU: return XLEN'(a < b);
      // Branch compares leave the result at zero
      default:  return '0;
    endcase
  endfunction

  function automatic logic expected_condition(alu_req_t req);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a = req.operand_a;
    b = req.operand_b;
    case (req.operator)
      ALU_SLTS, ALU_LTS: return $signed(a) < $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_GES:           return $signed(a) >= $signed(b);
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  // Full 64-bit product of the extended factors
  function automatic logic [XLEN-1:0] expected_mult_result(mult_req_t req);
    logic [2*XLEN-1:0] ext_a;
    logic [2*XLEN-1:0] ext_b;
    logic [2*XLEN-1:0] prod;
    ext_a = {{XLEN{req.signed_mode[0] & req.op_a[XLEN-1]}}, req.op_a};
    ext_b = {{XLEN{req.signed_mode[1] & req.op_b[XLEN-1]}}, req.op_b};
    prod  = ext_a * ext_b;
    case (req.operator)
      MUL_MAC: return prod[XLEN-1:0] + req.op_c;
      MUL_H:   return prod[2*XLEN-1:XLEN];
      default: return prod[XLEN-1:0];
    endcase
  endfunction

  // Stall rules, a branch never waits
  always_comb begin
    mulh_start_exp  = mult_en && (mult_req.operator == MUL_H) && !mulh_busy_q;
    units_ready_exp = !mulh_start_exp && lsu_ready_ex && wb_ready;
    ex_ready_exp    = units_ready_exp || branch_in_ex;
    ex_valid_exp    = (alu_en || mult_en || csr_access || lsu_en) && units_ready_exp;
    // Forwarded data by priority CSR, multiplier, ALU
    fw_exp.we       = regfile_alu_we;
    fw_exp.waddr    = regfile_alu_waddr;
    if (csr_access) begin
      fw_exp.wdata = csr_rdata;
    end else if (mult_en) begin
      fw_exp.wdata = expected_mult_result(mult_req);
    end else begin
      fw_exp.wdata = expected_alu_result(alu_req);
    end
    // First MULH cycle has no defined result
    check_fw = alu_en || csr_access || (mult_en && (mult_req.operator != MUL_H || mulh_busy_q));
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mulh_busy_q  <= 1'b0;
      wb_we_q      <= 1'b0;
      wb_waddr_q   <= '0;
      mulh_count   <= 0;
      bypass_count <= 0;
      hold_count   <= 0;
    end else begin
      if (mulh_busy_q && ex_ready_exp) begin
        mulh_busy_q <= 1'b0;
      end else if (mulh_start_exp) begin
        mulh_busy_q <= 1'b1;
      end
      // EX/WB slot, kept under back-pressure
      if (ex_valid_exp) begin
        wb_we_q <= regfile_we && !lsu_err;
        if (regfile_we && !lsu_err) begin
          wb_waddr_q <= regfile_waddr;
        end
      end else if (wb_ready) begin
        wb_we_q <= 1'b0;
      end
      if (mulh_start_exp) begin
        mulh_count <= mulh_count + 1;
      end
      if (branch_in_ex && !lsu_ready_ex) begin
        bypass_count <= bypass_count + 1;
      end
      if (wb_we_q && !wb_ready) begin
        hold_count <= hold_count + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    stop_with_failure();
  endtask

  fw_port_a : assert property (@(posedge clk) disable iff (!rst_n)
    check_fw |-> regfile_alu_fw == fw_exp)
    else report_mismatch("regfile_alu_fw_o", 64'(regfile_alu_fw), 64'(fw_exp));
  branch_a : assert property (@(posedge clk) disable iff (!rst_n)
    branch_decision == expected_condition(alu_req))
    else report_mismatch("branch_decision_o", 64'(branch_decision),
                         64'(expected_condition(alu_req)));
  jump_a : assert property (@(posedge clk) disable iff (!rst_n)
    jump_target == alu_req.operand_c)
    else report_mismatch("jump_target_o", 64'(jump_target), 64'(alu_req.operand_c));
  ready_a : assert property (@(posedge clk) disable iff (!rst_n) ex_ready == ex_ready_exp)
    else report_mismatch("ex_ready_o", 64'(ex_ready), 64'(ex_ready_exp));
  valid_a : assert property (@(posedge clk) disable iff (!rst_n) ex_valid == ex_valid_exp)
    else report_mismatch("ex_valid_o", 64'(ex_valid), 64'(ex_valid_exp));
  multicycle_a : assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle == mulh_busy_q)
    else report_mismatch("mult_multicycle_o", 64'(mult_multicycle), 64'(mulh_busy_q));
  // MULH stalls for one cycle only
  mulh_one_cycle_a : assert property (@(posedge clk) disable iff (!rst_n)
    mulh_start_exp |=> mult_multicycle)
    else report_mismatch("mult_multicycle_o", 64'(mult_multicycle), 64'(1));
  wb_we_a : assert property (@(posedge clk) disable iff (!rst_n) regfile_wb.we == wb_we_q)
    else report_mismatch("regfile_wb_o.we", 64'(regfile_wb.we), 64'(wb_we_q));
  wb_waddr_a : assert property (@(posedge clk) disable iff (!rst_n)
    wb_we_q |-> regfile_wb.waddr == wb_waddr_q)
    else report_mismatch("regfile_wb_o.waddr", 64'(regfile_wb.waddr), 64'(wb_waddr_q));
  wb_wdata_a : assert property (@(posedge clk) disable iff (!rst_n)
    wb_we_q |-> regfile_wb.wdata == lsu_rdata)
    else report_mismatch("regfile_wb_o.wdata", 64'(regfile_wb.wdata), 64'(lsu_rdata));
  // Covers the reset cycles and the first edge after release
  reset_wb_a : assert property (@(posedge clk) !rst_n |=> !regfile_wb.we)
    else report_mismatch("regfile_wb_o.we", 64'(regfile_wb.we), 64'(0));
  reset_mult_a : assert property (@(posedge clk) !rst_n |=> !mult_multicycle)
    else report_mismatch("mult_multicycle_o", 64'(mult_multicycle), 64'(0));

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_idle();
    {alu_en, mult_en, csr_access, lsu_en, lsu_err, branch_in_ex} = '0;
    {regfile_alu_we, regfile_we, regfile_alu_waddr, regfile_waddr} = '0;
    {alu_req, mult_req, csr_rdata, lsu_rdata} = '0;
    lsu_ready_ex = 1'b1;
    wb_ready     = 1'b1;
  endtask

  // Ready about three cycles in four
  task automatic randomize_backpressure();
    logic [31:0] r;
    r            = $random(seed);
    lsu_ready_ex = (r[1:0] != 2'b00);
    wb_ready     = (r[3:2] != 2'b00);
    lsu_rdata    = $random(seed);
  endtask

  task automatic load_instruction(output logic idle);
    logic [31:0] r;
    logic [31:0] k;
    r = $random(seed);
    k = $random(seed);
    alu_req.operator     = alu_op_e'(r[3:0]);
    alu_req.operand_a    = $random(seed);
    alu_req.operand_b    = $random(seed);
    alu_req.operand_c    = $random(seed);
    mult_req.operator    = mul_op_e'(2'(k[31:4] % 28'd3));
    mult_req.signed_mode = r[9:8];
    mult_req.op_a        = $random(seed);
    mult_req.op_b        = $random(seed);
    mult_req.op_c        = $random(seed);
    csr_rdata            = $random(seed);
    // Kinds 0 to 2 ALU, 3 and 4 multiplier, then CSR, LSU and a bubble
    alu_en            = (k[2:0] <= 3'd2);
    mult_en           = (k[2:0] == 3'd3) || (k[2:0] == 3'd4);
    csr_access        = (k[2:0] == 3'd5);
    lsu_en            = (k[2:0] == 3'd6);
    idle              = (k[2:0] == 3'd7);
    branch_in_ex      = alu_en && (alu_req.operator >= ALU_EQ) && r[26];
    regfile_alu_waddr = r[15:10];
    regfile_waddr     = r[21:16];
    regfile_alu_we    = r[22] && !lsu_en;
    lsu_err           = (r[25:23] == 3'b000);
    regfile_we        = lsu_en && r[27];
  endtask

  // Hold the instruction until ex_ready_o is high at a rising edge
  task automatic run_instruction();
    logic        idle;
    logic        accepted;
    int unsigned waited;
    load_instruction(idle);
    waited   = 0;
    accepted = 1'b0;
    while (!accepted) begin
      randomize_backpressure();
      #1;
      accepted = idle || ex_ready;
      if (!accepted) begin
        waited++;
        if (waited > MAX_WAIT) begin
          $display("Timeout: ex_ready_o stayed low for %0d cycles", waited);
          stop_with_failure();
        end
      end
      @(negedge clk);
    end
  endtask

  initial begin
    int unsigned waited;
    seed = 32'hb28f96aa;
    drive_idle();
    waited = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      waited++;
      if (waited > MAX_RESET) begin
        $display("Timeout: reset was never released");
        stop_with_failure();
      end
    end
    @(negedge clk);
    for (int i = 0; i < NUM_INSTR; i++) begin
      run_instruction();
    end
    drive_idle();
    repeat (4) @(negedge clk);
    if (mulh_count == 0 || bypass_count == 0 || hold_count == 0) begin
      $display("Stimulus never reached MULH, branch bypass or a held EX/WB slot");
      stop_with_failure();
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// File: ex_stage.f
design/ex_isa_pkg.sv
design/ex_pipe_pkg.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_writeback.sv
design/ex_stage.sv
verification/tb_clock_gen.sv
verification/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=ex_stage_sim

verilator --binary --timing --assert -j 0 \
  --top-module ex_stage_tb \
  -f ex_stage.f \
  --Mdir "$BUILD_DIR" -o "$SIM_EXE"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

"./$BUILD_DIR/$SIM_EXE"
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
fi
exit $status
